// File: hw/id_decoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "id_settings.svh"

module id_decoder
  import isa_pkg::*;
  import id_pkg::*;
(
  input  logic [`ID_XLEN-1:0]       instr_i,
  output unit_e                     unit_o,
  output alu_op_e                   alu_op_o,
  output sys_op_e                   sys_op_o,
  output opb_sel_e                  opb_sel_o,
  output imm_kind_e                 imm_kind_o,
  output logic [`ID_REG_ADDR_W-1:0] rs1_addr_o,
  output logic [`ID_REG_ADDR_W-1:0] rs2_addr_o,
  output logic [`ID_REG_ADDR_W-1:0] rd_addr_o,
  output logic                      rf_we_o,
  output logic                      lsu_we_o,
  output logic                      illegal_o
);

  opcode_e     opcode;
  sys_funct3_e sys_f3;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  alu_op_e     f3_alu_op;
  logic        f3_alu_ok;
  logic        is_shift;
  unit_e       unit;
  sys_op_e     sys_op;
  logic        rf_we;
  logic        lsu_we;
  logic        illegal;

  assign opcode     = opcode_e'(instr_i[6:0]);
  assign funct3     = instr_i[14:12];
  assign funct7     = instr_i[31:25];
  assign sys_f3     = sys_funct3_e'(funct3);
  assign rd_addr_o  = instr_i[11:7];
  assign rs1_addr_o = instr_i[19:15];
  assign rs2_addr_o = instr_i[24:20];
  assign is_shift   = (funct3 == 3'b001) || (funct3 == 3'b101);

  //////////////////////////////////////////////////
  // ALU operation from funct3
  //////////////////////////////////////////////////

  // Shared by OP and OP-IMM; only OP may turn ADD into SUB
  always_comb begin
    f3_alu_ok = 1'b1;
    case (funct3)
      3'b000:  f3_alu_op = (opcode == OPC_OP && funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
      3'b001:  f3_alu_op = ALU_SLL;
      3'b010:  f3_alu_op = ALU_SLT;
      3'b100:  f3_alu_op = ALU_XOR;
      3'b101:  f3_alu_op = ALU_SRL;
      3'b110:  f3_alu_op = ALU_OR;
      3'b111:  f3_alu_op = ALU_AND;
      default: begin
        // SLTU is outside the supported subset
        f3_alu_op = ALU_ADD;
        f3_alu_ok = 1'b0;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Main decode
  //////////////////////////////////////////////////

  always_comb begin
    unit       = UNIT_NONE;
    alu_op_o   = ALU_ADD;
    sys_op     = SYSOP_NONE;
    opb_sel_o  = OPB_REG;
    imm_kind_o = IMM_NONE;
    rf_we      = 1'b0;
    lsu_we     = 1'b0;
    illegal    = 1'b0;
    case (opcode)
      OPC_OP: begin
        rf_we = 1'b1;
        if (funct7 == F7_MULDIV) begin
          // funct3 bit 2 splits the M extension into multiply and divide
          unit = funct3[2] ? UNIT_DIV : UNIT_MUL;
        end else begin
          unit     = UNIT_ALU;
          alu_op_o = f3_alu_op;
          illegal  = !f3_alu_ok ||
                     !(funct7 == F7_BASE || (funct7 == F7_SUB && funct3 == 3'b000));
        end
      end
      OPC_OP_IMM: begin
        unit       = UNIT_ALU;
        alu_op_o   = f3_alu_op;
        opb_sel_o  = OPB_IMM;
        imm_kind_o = IMM_I;
        rf_we      = 1'b1;
        // Shift immediates keep funct7 at zero, SRAI is not supported
        illegal    = !f3_alu_ok || (is_shift && funct7 != F7_BASE);
      end
      OPC_LOAD: begin
        // Address is rs1 plus the I immediate through the ALU adder
        unit       = UNIT_LSU;
        opb_sel_o  = OPB_IMM;
        imm_kind_o = IMM_I;
        rf_we      = 1'b1;
        illegal    = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
      end
      OPC_STORE: begin
        // Operand B carries the store data from rs2
        unit       = UNIT_LSU;
        imm_kind_o = IMM_S;
        lsu_we     = 1'b1;
        illegal    = (funct3 > 3'b010);
      end
      OPC_SYSTEM: begin
        case (sys_f3)
          F3_PRIV: begin
            unit = UNIT_SYS;
            case (instr_i)
              INSTR_ECALL:  sys_op = SYSOP_ECALL;
              INSTR_EBREAK: sys_op = SYSOP_EBREAK;
              INSTR_MRET:   sys_op = SYSOP_MRET;
              INSTR_WFI:    sys_op = SYSOP_WFI;
              default:      illegal = 1'b1;
            endcase
          end
          F3_CSRRW, F3_CSRRS, F3_CSRRC: begin
            // The CSR address rides in operand B as an I immediate
            unit       = UNIT_CSR;
            opb_sel_o  = OPB_IMM;
            imm_kind_o = IMM_I;
            rf_we      = 1'b1;
          end
          default: illegal = 1'b1;
        endcase
      end
      default: illegal = 1'b1;
    endcase
  end

  // Squash every side effect of an illegal instruction
  assign illegal_o = illegal;
  assign unit_o    = illegal ? UNIT_NONE : unit;
  assign sys_op_o  = illegal ? SYSOP_NONE : sys_op;
  assign rf_we_o   = rf_we && !illegal;
  assign lsu_we_o  = lsu_we && !illegal;

  always_comb begin
    // Every legal instruction is sent to exactly one unit
    a_unit_onehot : assert final (illegal_o || unit_o != UNIT_NONE);
    a_illegal : assert final (!illegal_o || (unit_o == UNIT_NONE && !rf_we_o && !lsu_we_o));
    a_sys_op : assert final (unit_o == UNIT_SYS || sys_op_o == SYSOP_NONE);
  end

endmodule

`default_nettype wire

// File: hw/id_operand_sel.sv
`timescale 1ns/100ps
`default_nettype none

`include "id_settings.svh"

module id_operand_sel
  import isa_pkg::*;
  import id_pkg::*;
(
  input  logic [`ID_XLEN-1:0]       instr_i,
  input  logic                      dummy_i,
  input  logic [`ID_REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [`ID_REG_ADDR_W-1:0] rs2_addr_i,
  input  logic [`ID_XLEN-1:0]       rdata_a_i,
  input  logic [`ID_XLEN-1:0]       rdata_b_i,
  input  opb_sel_e                  opb_sel_i,
  input  imm_kind_e                 imm_kind_i,
  output logic [`ID_XLEN-1:0]       operand_a_o,
  output logic [`ID_XLEN-1:0]       operand_b_o
);

  logic                rs1_zero;
  logic                rs2_zero;
  logic [`ID_XLEN-1:0] rs2_value;
  logic [`ID_XLEN-1:0] imm_i;
  logic [`ID_XLEN-1:0] imm_s;
  logic [`ID_XLEN-1:0] imm;

  // Regular instructions see zero in register 0, dummies see the stored value
  assign rs1_zero    = (rs1_addr_i == '0) && !dummy_i;
  assign rs2_zero    = (rs2_addr_i == '0) && !dummy_i;
  assign operand_a_o = rs1_zero ? '0 : rdata_a_i;
  assign rs2_value   = rs2_zero ? '0 : rdata_b_i;

  // Sign-extended immediates
  assign imm_i = {{(`ID_XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{(`ID_XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};

  always_comb begin
    case (imm_kind_i)
      IMM_I:   imm = imm_i;
      IMM_S:   imm = imm_s;
      default: imm = '0;
    endcase
  end

  // Stores keep OPB_REG so operand B is the store data
  assign operand_b_o = (opb_sel_i == OPB_IMM) ? imm : rs2_value;

  always_comb begin
    a_r0_regular : assert final (dummy_i || ((rs1_addr_i != '0 || operand_a_o == '0) &&
      (rs2_addr_i != '0 || opb_sel_i == OPB_IMM || operand_b_o == '0)));
    a_r0_dummy : assert final (!dummy_i || ((rs1_addr_i != '0 || operand_a_o == rdata_a_i) &&
      (rs2_addr_i != '0 || opb_sel_i == OPB_IMM || operand_b_o == rdata_b_i)));
  end

endmodule

`default_nettype wire

// File: hw/id_pipe_reg.sv
`timescale 1ns/100ps
`default_nettype none

module id_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n_i,
  input  logic     in_valid_i,
  input  payload_t in_data_i,
  output logic     in_ready_o,
  input  logic     halt_i,
  input  logic     kill_i,
  output logic     out_valid_o,
  output payload_t out_data_o,
  input  logic     out_ready_i
);

  logic     valid_q;
  payload_t data_q;
  logic     load;

  // Kill always accepts so the upstream item is dropped
  // Otherwise accept when empty or when the held item leaves this cycle
  assign in_ready_o  = kill_i || (!halt_i && (!valid_q || out_ready_i));
  assign out_valid_o = valid_q && !halt_i && !kill_i;
  assign out_data_o  = data_q;

  // A killed cycle loads nothing
  assign load = !kill_i && in_valid_i && in_ready_o;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (kill_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      data_q <= in_data_i;
    end
  end

  // Halt without kill blocks both sides and keeps the held item
  a_halt : assert property (@(posedge clk) disable iff (!rst_n_i)
    (halt_i && !kill_i) |-> (!in_ready_o && !out_valid_o) ##1 $stable(valid_q));

  // Kill drops the item, so nothing is offered downstream
  a_kill : assert property (@(posedge clk) disable iff (!rst_n_i)
    kill_i |-> (in_ready_o && !out_valid_o));

endmodule

`default_nettype wire

// File: hw/id_pkg.sv
`default_nettype none

package id_pkg;

  // Functional unit that receives the instruction
  // UNIT_NONE means no unit at all
  typedef enum logic [2:0] {
    UNIT_NONE = 3'd0,
    UNIT_ALU  = 3'd1,
    UNIT_MUL  = 3'd2,
    UNIT_DIV  = 3'd3,
    UNIT_LSU  = 3'd4,
    UNIT_CSR  = 3'd5,
    UNIT_SYS  = 3'd6
  } unit_e;

  // Operation performed by the ALU, also used for LSU address generation
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
    ALU_XOR, ALU_SLT, ALU_SLL, ALU_SRL
  } alu_op_e;

  // Source of operand B
  typedef enum logic {
    OPB_REG,
    OPB_IMM
  } opb_sel_e;

  // System operation carried toward execute
  typedef enum logic [2:0] {
    SYSOP_NONE, SYSOP_ECALL, SYSOP_EBREAK, SYSOP_MRET, SYSOP_WFI
  } sys_op_e;

endpackage

`default_nettype wire

// File: hw/id_regfile.sv
`timescale 1ns/100ps
`default_nettype none

`include "id_settings.svh"

module id_regfile (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic [`ID_REG_ADDR_W-1:0] raddr_a_i,
  input  logic [`ID_REG_ADDR_W-1:0] raddr_b_i,
  output logic [`ID_XLEN-1:0]       rdata_a_o,
  output logic [`ID_XLEN-1:0]       rdata_b_o,
  input  logic                      we_i,
  input  logic [`ID_REG_ADDR_W-1:0] waddr_i,
  input  logic [`ID_XLEN-1:0]       wdata_i
);

  // Register 0 is real storage so that dummy instructions can read it
  logic [`ID_XLEN-1:0] regs_q [`ID_NUM_REGS];

  // Reads see the value from before this cycle's write
  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `ID_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // A write-back strobe must come with known address and data
  a_wdata_known : assert property (@(posedge clk) disable iff (!rst_n_i)
    we_i |-> !$isunknown({waddr_i, wdata_i}));

endmodule

`default_nettype wire

// File: hw/id_settings.svh
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

//////////////////////////////////////////////////
// Decode stage dimensions
//////////////////////////////////////////////////

// Width of a data word and of an instruction word
`define ID_XLEN 32

// Width of a register index as found in the rs1, rs2 and rd fields
`define ID_REG_ADDR_W 5

// Number of architectural registers
// Register 0 is counted here because it has real storage
`define ID_NUM_REGS 32

`endif

// File: hw/id_stage_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "id_settings.svh"

module id_stage_top
  import isa_pkg::*;
  import id_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic                      in_valid_i,
  input  logic [`ID_XLEN-1:0]       in_instr_i,
  input  logic                      in_dummy_i,
  output logic                      in_ready_o,
  input  logic                      halt_i,
  input  logic                      kill_i,
  input  logic                      wb_we_i,
  input  logic [`ID_REG_ADDR_W-1:0] wb_addr_i,
  input  logic [`ID_XLEN-1:0]       wb_data_i,
  input  logic                      ex_ready_i,
  output logic                      ex_valid_o,
  output unit_e                     ex_unit_o,
  output alu_op_e                   ex_alu_op_o,
  output sys_op_e                   ex_sys_op_o,
  output logic [`ID_XLEN-1:0]       ex_operand_a_o,
  output logic [`ID_XLEN-1:0]       ex_operand_b_o,
  output logic [`ID_REG_ADDR_W-1:0] ex_rd_addr_o,
  output logic                      ex_rf_we_o,
  output logic                      ex_lsu_we_o,
  output logic                      ex_illegal_o
);

  // Item held between fetch and decode
  typedef struct packed {
    logic [`ID_XLEN-1:0] instr;
    logic                dummy;
  } if_id_t;

  // Item held between decode and execute
  typedef struct packed {
    unit_e                     unit;
    alu_op_e                   alu_op;
    sys_op_e                   sys_op;
    logic [`ID_XLEN-1:0]       operand_a;
    logic [`ID_XLEN-1:0]       operand_b;
    logic [`ID_REG_ADDR_W-1:0] rd_addr;
    logic                      rf_we;
    logic                      lsu_we;
    logic                      illegal;
  } id_ex_t;

  if_id_t                    if_id_d;
  if_id_t                    if_id_q;
  logic                      if_id_valid;
  logic                      id_ex_ready;
  id_ex_t                    id_ex_d;
  id_ex_t                    id_ex_q;
  opb_sel_e                  opb_sel;
  imm_kind_e                 imm_kind;
  logic [`ID_REG_ADDR_W-1:0] rs1_addr;
  logic [`ID_REG_ADDR_W-1:0] rs2_addr;
  logic [`ID_XLEN-1:0]       rdata_a;
  logic [`ID_XLEN-1:0]       rdata_b;

  assign if_id_d.instr = in_instr_i;
  assign if_id_d.dummy = in_dummy_i;

  //////////////////////////////////////////////////
  // Input register, the only one halted or killed
  //////////////////////////////////////////////////

  id_pipe_reg #(.payload_t(if_id_t)) u_if_id (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_data_i   (if_id_d),
    .in_ready_o  (in_ready_o),
    .halt_i      (halt_i),
    .kill_i      (kill_i),
    .out_valid_o (if_id_valid),
    .out_data_o  (if_id_q),
    .out_ready_i (id_ex_ready)
  );

  //////////////////////////////////////////////////
  // Decode, register read and operand selection
  //////////////////////////////////////////////////

  id_decoder u_decoder (
    .instr_i    (if_id_q.instr),
    .unit_o     (id_ex_d.unit),
    .alu_op_o   (id_ex_d.alu_op),
    .sys_op_o   (id_ex_d.sys_op),
    .opb_sel_o  (opb_sel),
    .imm_kind_o (imm_kind),
    .rs1_addr_o (rs1_addr),
    .rs2_addr_o (rs2_addr),
    .rd_addr_o  (id_ex_d.rd_addr),
    .rf_we_o    (id_ex_d.rf_we),
    .lsu_we_o   (id_ex_d.lsu_we),
    .illegal_o  (id_ex_d.illegal)
  );

  id_regfile u_regfile (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .raddr_a_i (rs1_addr),
    .raddr_b_i (rs2_addr),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .we_i      (wb_we_i),
    .waddr_i   (wb_addr_i),
    .wdata_i   (wb_data_i)
  );

  id_operand_sel u_operand_sel (
    .instr_i     (if_id_q.instr),
    .dummy_i     (if_id_q.dummy),
    .rs1_addr_i  (rs1_addr),
    .rs2_addr_i  (rs2_addr),
    .rdata_a_i   (rdata_a),
    .rdata_b_i   (rdata_b),
    .opb_sel_i   (opb_sel),
    .imm_kind_i  (imm_kind),
    .operand_a_o (id_ex_d.operand_a),
    .operand_b_o (id_ex_d.operand_b)
  );

  // Output register toward execute, never halted or killed
  id_pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (if_id_valid),
    .in_data_i   (id_ex_d),
    .in_ready_o  (id_ex_ready),
    .halt_i      (1'b0),
    .kill_i      (1'b0),
    .out_valid_o (ex_valid_o),
    .out_data_o  (id_ex_q),
    .out_ready_i (ex_ready_i)
  );

  assign ex_unit_o      = id_ex_q.unit;
  assign ex_alu_op_o    = id_ex_q.alu_op;
  assign ex_sys_op_o    = id_ex_q.sys_op;
  assign ex_operand_a_o = id_ex_q.operand_a;
  assign ex_operand_b_o = id_ex_q.operand_b;
  assign ex_rd_addr_o   = id_ex_q.rd_addr;
  assign ex_rf_we_o     = id_ex_q.rf_we;
  assign ex_lsu_we_o    = id_ex_q.lsu_we;
  assign ex_illegal_o   = id_ex_q.illegal;

  // Halt without kill closes the stage input
  a_halt_not_ready : assert property (@(posedge clk) disable iff (!rst_n_i)
    (halt_i && !kill_i) |-> !in_ready_o);

  // Kill keeps the stage input open
  a_kill_ready : assert property (@(posedge clk) disable iff (!rst_n_i)
    kill_i |-> in_ready_o);

  // While halted or killed nothing reaches execute, so a drained output stays empty
  a_stall_no_issue : assert property (@(posedge clk) disable iff (!rst_n_i)
    ((halt_i || kill_i) && (!ex_valid_o || ex_ready_i)) |=> !ex_valid_o);

endmodule

`default_nettype wire

// File: hw/isa_pkg.sv
`default_nettype none

package isa_pkg;

  // Major opcodes in bits 6:0 of the instruction word
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'h03,
    OPC_OP_IMM = 7'h13,
    OPC_STORE  = 7'h23,
    OPC_OP     = 7'h33,
    OPC_SYSTEM = 7'h73
  } opcode_e;

  // funct3 codes of the SYSTEM opcode
  // PRIV holds ECALL, EBREAK, MRET and WFI, told apart by the whole word
  typedef enum logic [2:0] {
    F3_PRIV  = 3'b000,
    F3_CSRRW = 3'b001,
    F3_CSRRS = 3'b010,
    F3_CSRRC = 3'b011
  } sys_funct3_e;

  // Immediate formats the stage can build
  typedef enum logic [1:0] {
    IMM_NONE = 2'b00,
    IMM_I    = 2'b01,
    IMM_S    = 2'b10
  } imm_kind_e;

  // Complete encodings of the privileged instructions
  localparam logic [31:0] INSTR_ECALL  = 32'h0000_0073;
  localparam logic [31:0] INSTR_EBREAK = 32'h0010_0073;
  localparam logic [31:0] INSTR_MRET   = 32'h3020_0073;
  localparam logic [31:0] INSTR_WFI    = 32'h1050_0073;

  // funct7 values that OP accepts
  localparam logic [6:0] F7_BASE   = 7'b000_0000;
  localparam logic [6:0] F7_MULDIV = 7'b000_0001;
  localparam logic [6:0] F7_SUB    = 7'b010_0000;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the decode-stage testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -f vlog.f --top-module tb_id_stage -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_id_stage" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "test passed" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: verification/tb_id_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "id_settings.svh"

module tb_id_stage
  import id_pkg::*;
();

  localparam int CLK_PERIOD     = 20;
  localparam int SETTLE         = 5;
  localparam int RAND_SEED      = 45;
  localparam int OUT_WAIT_LIMIT = 8;

  // Rough cycle counts of each test
  localparam int LEN_RESET      = 4;
  localparam int LEN_ALU        = 40;
  localparam int LEN_UNITS      = 20;
  localparam int LEN_REG0       = 8;
  localparam int LEN_ILLEGAL    = 12;
  localparam int LEN_CONTROL    = 30;
  localparam int TIMEOUT_CYCLES = 2 * (LEN_RESET + LEN_ALU + LEN_UNITS + LEN_REG0 +
                                       LEN_ILLEGAL + LEN_CONTROL);

  // Major opcodes and privileged words as the ISA manual gives them
  localparam logic [6:0]  OP_LOAD     = 7'h03;
  localparam logic [6:0]  OP_IMM      = 7'h13;
  localparam logic [6:0]  OP_STORE    = 7'h23;
  localparam logic [6:0]  OP_REG      = 7'h33;
  localparam logic [6:0]  OP_SYSTEM   = 7'h73;
  localparam logic [31:0] ECALL_WORD  = 32'h0000_0073;
  localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;
  localparam logic [31:0] MRET_WORD   = 32'h3020_0073;
  localparam logic [31:0] WFI_WORD    = 32'h1050_0073;

  logic                      clk;
  logic                      rst_n_i;
  logic                      in_valid_i;
  logic [`ID_XLEN-1:0]       in_instr_i;
  logic                      in_dummy_i;
  logic                      in_ready_o;
  logic                      halt_i;
  logic                      kill_i;
  logic                      wb_we_i;
  logic [`ID_REG_ADDR_W-1:0] wb_addr_i;
  logic [`ID_XLEN-1:0]       wb_data_i;
  logic                      ex_ready_i;
  logic                      ex_valid_o;
  unit_e                     ex_unit_o;
  alu_op_e                   ex_alu_op_o;
  sys_op_e                   ex_sys_op_o;
  logic [`ID_XLEN-1:0]       ex_operand_a_o;
  logic [`ID_XLEN-1:0]       ex_operand_b_o;
  logic [`ID_REG_ADDR_W-1:0] ex_rd_addr_o;
  logic                      ex_rf_we_o;
  logic                      ex_lsu_we_o;
  logic                      ex_illegal_o;

  // Expected register contents, kept in step with every write-back
  logic [`ID_XLEN-1:0] reg_model [`ID_NUM_REGS];
  string               test_name;
  int                  error_count = 0;
  int                  cycle_count = 0;

  id_stage_top dut (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .in_valid_i     (in_valid_i),
    .in_instr_i     (in_instr_i),
    .in_dummy_i     (in_dummy_i),
    .in_ready_o     (in_ready_o),
    .halt_i         (halt_i),
    .kill_i         (kill_i),
    .wb_we_i        (wb_we_i),
    .wb_addr_i      (wb_addr_i),
    .wb_data_i      (wb_data_i),
    .ex_ready_i     (ex_ready_i),
    .ex_valid_o     (ex_valid_o),
    .ex_unit_o      (ex_unit_o),
    .ex_alu_op_o    (ex_alu_op_o),
    .ex_sys_op_o    (ex_sys_op_o),
    .ex_operand_a_o (ex_operand_a_o),
    .ex_operand_b_o (ex_operand_b_o),
    .ex_rd_addr_o   (ex_rd_addr_o),
    .ex_rf_we_o     (ex_rf_we_o),
    .ex_lsu_we_o    (ex_lsu_we_o),
    .ex_illegal_o   (ex_illegal_o)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // A stuck handshake ends the run here
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("errors: %0d", error_count + 1);
      $display("test failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Instruction encoders and expected values
  //////////////////////////////////////////////////

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
      input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  // The S format splits the offset around the rs fields
  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // Register 0 reads as zero except for a dummy instruction
  function automatic logic [31:0] read_value(input logic [4:0] addr, input logic dummy);
    if (addr == 5'd0 && !dummy) begin
      return 32'h0;
    end
    return reg_model[addr];
  endfunction

  //////////////////////////////////////////////////
  // Driving and checking tasks
  //////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] expected,
      input logic [31:0] actual);
    if (actual !== expected) begin
      error_count++;
      $display("ERROR %s %s: expected 0x%08h, actual 0x%08h", test_name, what, expected,
               actual);
    end
  endtask

  // Every task starts and ends just after a falling edge
  task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
    wb_we_i   = 1'b1;
    wb_addr_i = addr;
    wb_data_i = data;
    reg_model[addr] = data;
    @(negedge clk);
    wb_we_i = 1'b0;
  endtask

  // Holds valid until in_ready_o is seen high in the middle of a cycle
  task automatic send_instr(input logic [31:0] instr, input logic dummy);
    in_valid_i = 1'b1;
    in_instr_i = instr;
    in_dummy_i = dummy;
    #SETTLE;
    while (!in_ready_o) begin
      @(negedge clk);
      #SETTLE;
    end
    @(negedge clk);
    in_valid_i = 1'b0;
    in_dummy_i = 1'b0;
  endtask

  task automatic wait_output(output int cycles);
    cycles = 0;
    while (!ex_valid_o && cycles < OUT_WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!ex_valid_o) begin
      error_count++;
      $display("%s: no instruction reached execute within %0d cycles", test_name,
               OUT_WAIT_LIMIT);
    end
  endtask

  // Output is due one cycle after the input register takes the word
  task automatic issue(input logic [31:0] instr, input logic dummy);
    int cycles;
    send_instr(instr, dummy);
    wait_output(cycles);
    check_value("latency", 32'd1, 32'(cycles));
  endtask

  task automatic check_decode(input unit_e exp_unit, input sys_op_e exp_sys,
      input logic rf_we, input logic lsu_we, input logic illegal);
    check_value("unit", 32'(exp_unit), 32'(ex_unit_o));
    check_value("sys_op", 32'(exp_sys), 32'(ex_sys_op_o));
    check_value("rf_we", 32'(rf_we), 32'(ex_rf_we_o));
    check_value("lsu_we", 32'(lsu_we), 32'(ex_lsu_we_o));
    check_value("illegal", 32'(illegal), 32'(ex_illegal_o));
  endtask

  task automatic check_alu(input alu_op_e op, input logic [4:0] rs1,
      input logic [31:0] opb, input logic [4:0] rd);
    check_decode(UNIT_ALU, SYSOP_NONE, 1'b1, 1'b0, 1'b0);
    check_value("alu_op", 32'(op), 32'(ex_alu_op_o));
    check_value("operand_a", read_value(rs1, 1'b0), ex_operand_a_o);
    check_value("operand_b", opb, ex_operand_b_o);
    check_value("rd", 32'(rd), 32'(ex_rd_addr_o));
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic test_reset();
    test_name = "reset";
    check_value("ex_valid_o", 32'd0, 32'(ex_valid_o));
    check_value("in_ready_o", 32'd1, 32'(in_ready_o));
  endtask

  task automatic test_alu();
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [11:0] imm;
    test_name = "alu";
    for (int i = 1; i < `ID_NUM_REGS; i++) begin
      write_reg(5'(i), $urandom);
    end
    rs1 = 5'($urandom_range(31, 1));
    rs2 = 5'($urandom_range(31, 1));
    rd  = 5'($urandom_range(31, 1));
    test_name = "add";
    issue(enc_r(7'h00, rs2, rs1, 3'b000, rd, OP_REG), 1'b0);
    check_alu(ALU_ADD, rs1, read_value(rs2, 1'b0), rd);
    test_name = "sub";
    issue(enc_r(7'h20, rs1, rs2, 3'b000, rd, OP_REG), 1'b0);
    check_alu(ALU_SUB, rs2, read_value(rs1, 1'b0), rd);
    // Top bit forced so the sign extension is exercised
    imm = 12'($urandom) | 12'h800;
    test_name = "addi";
    issue(enc_i(imm, rs1, 3'b000, rd, OP_IMM), 1'b0);
    check_alu(ALU_ADD, rs1, sext12(imm), rd);
  endtask

  task automatic test_units();
    test_name = "mul";
    issue(enc_r(7'h01, 5'd6, 5'd5, 3'b000, 5'd7, OP_REG), 1'b0);
    check_decode(UNIT_MUL, SYSOP_NONE, 1'b1, 1'b0, 1'b0);
    test_name = "div";
    issue(enc_r(7'h01, 5'd6, 5'd5, 3'b100, 5'd7, OP_REG), 1'b0);
    check_decode(UNIT_DIV, SYSOP_NONE, 1'b1, 1'b0, 1'b0);
    // LW computes its address as rs1 plus offset through the ALU adder
    test_name = "load";
    issue(enc_i(12'hffc, 5'd5, 3'b010, 5'd8, OP_LOAD), 1'b0);
    check_decode(UNIT_LSU, SYSOP_NONE, 1'b1, 1'b0, 1'b0);
    check_value("alu_op", 32'(ALU_ADD), 32'(ex_alu_op_o));
    check_value("operand_a", read_value(5'd5, 1'b0), ex_operand_a_o);
    check_value("operand_b", sext12(12'hffc), ex_operand_b_o);
    test_name = "store";
    issue(enc_s(12'h008, 5'd6, 5'd5, 3'b010), 1'b0);
    check_decode(UNIT_LSU, SYSOP_NONE, 1'b0, 1'b1, 1'b0);
    check_value("store data", read_value(5'd6, 1'b0), ex_operand_b_o);
    test_name = "csrrw";
    issue(enc_i(12'h300, 5'd5, 3'b001, 5'd9, OP_SYSTEM), 1'b0);
    check_decode(UNIT_CSR, SYSOP_NONE, 1'b1, 1'b0, 1'b0);
    test_name = "ecall";
    issue(ECALL_WORD, 1'b0);
    check_decode(UNIT_SYS, SYSOP_ECALL, 1'b0, 1'b0, 1'b0);
    test_name = "ebreak";
    issue(EBREAK_WORD, 1'b0);
    check_decode(UNIT_SYS, SYSOP_EBREAK, 1'b0, 1'b0, 1'b0);
    test_name = "mret";
    issue(MRET_WORD, 1'b0);
    check_decode(UNIT_SYS, SYSOP_MRET, 1'b0, 1'b0, 1'b0);
    test_name = "wfi";
    issue(WFI_WORD, 1'b0);
    check_decode(UNIT_SYS, SYSOP_WFI, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic test_reg0();
    logic [31:0] r0_value;
    logic [31:0] add_r0;
    test_name = "reg0";
    r0_value = $urandom | 32'h1;
    add_r0   = enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd10, OP_REG);
    write_reg(5'd0, r0_value);
    issue(add_r0, 1'b0);
    check_value("operand_a", 32'h0, ex_operand_a_o);
    check_value("operand_b", 32'h0, ex_operand_b_o);
    test_name = "reg0 dummy";
    issue(add_r0, 1'b1);
    check_value("operand_a", r0_value, ex_operand_a_o);
    check_value("operand_b", r0_value, ex_operand_b_o);
  endtask

  task automatic test_illegal();
    logic [31:0] words [5];
    words[0] = 32'h0000_006f;
    words[1] = 32'h0000_0063;
    // SLL with the SUB funct7
    words[2] = enc_r(7'h20, 5'd2, 5'd1, 3'b001, 5'd3, OP_REG);
    // Reserved SYSTEM funct3
    words[3] = enc_i(12'h000, 5'd1, 3'b100, 5'd3, OP_SYSTEM);
    words[4] = 32'h0020_0073;
    foreach (words[i]) begin
      test_name = $sformatf("illegal %0d", i);
      issue(words[i], 1'b0);
      check_decode(UNIT_NONE, SYSOP_NONE, 1'b0, 1'b0, 1'b1);
    end
  endtask

  task automatic test_halt();
    int cycles;
    test_name = "halt";
    send_instr(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd13, OP_REG), 1'b0);
    // First item waits in the input register and a second one is offered
    halt_i     = 1'b1;
    in_valid_i = 1'b1;
    in_instr_i = enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd14, OP_REG);
    repeat (3) begin
      #SETTLE;
      check_value("in_ready_o", 32'd0, 32'(in_ready_o));
      @(negedge clk);
      check_value("ex_valid_o", 32'd0, 32'(ex_valid_o));
    end
    halt_i     = 1'b0;
    in_valid_i = 1'b0;
    wait_output(cycles);
    check_value("held rd", 32'd13, 32'(ex_rd_addr_o));
    repeat (3) begin
      @(negedge clk);
      check_value("ex_valid_o after release", 32'd0, 32'(ex_valid_o));
    end
  endtask

  task automatic test_kill();
    test_name  = "kill";
    ex_ready_i = 1'b0;
    send_instr(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd15, OP_REG), 1'b0);
    send_instr(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd16, OP_REG), 1'b0);
    check_value("ex_valid_o", 32'd1, 32'(ex_valid_o));
    kill_i = 1'b1;
    #SETTLE;
    check_value("in_ready_o", 32'd1, 32'(in_ready_o));
    @(negedge clk);
    kill_i = 1'b0;
    check_value("rd before drain", 32'd15, 32'(ex_rd_addr_o));
    ex_ready_i = 1'b1;
    // The killed item must never show up
    repeat (4) begin
      @(negedge clk);
      check_value("ex_valid_o after kill", 32'd0, 32'(ex_valid_o));
    end
  endtask

  task automatic test_backpressure();
    test_name  = "backpressure";
    ex_ready_i = 1'b0;
    send_instr(enc_r(7'h00, 5'd4, 5'd3, 3'b000, 5'd17, OP_REG), 1'b0);
    send_instr(enc_r(7'h00, 5'd6, 5'd5, 3'b000, 5'd18, OP_REG), 1'b0);
    in_valid_i = 1'b1;
    in_instr_i = enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd19, OP_REG);
    repeat (3) begin
      #SETTLE;
      check_value("in_ready_o", 32'd0, 32'(in_ready_o));
      @(negedge clk);
      check_value("ex_valid_o", 32'd1, 32'(ex_valid_o));
      check_value("held rd", 32'd17, 32'(ex_rd_addr_o));
      check_value("held operand_a", read_value(5'd3, 1'b0), ex_operand_a_o);
      check_value("held operand_b", read_value(5'd4, 1'b0), ex_operand_b_o);
    end
    ex_ready_i = 1'b1;
    @(negedge clk);
    in_valid_i = 1'b0;
    check_value("second valid", 32'd1, 32'(ex_valid_o));
    check_value("second rd", 32'd18, 32'(ex_rd_addr_o));
    @(negedge clk);
    check_value("third valid", 32'd1, 32'(ex_valid_o));
    check_value("third rd", 32'd19, 32'(ex_rd_addr_o));
    @(negedge clk);
    check_value("drained", 32'd0, 32'(ex_valid_o));
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(RAND_SEED));
    rst_n_i    = 1'b0;
    in_valid_i = 1'b0;
    in_instr_i = '0;
    in_dummy_i = 1'b0;
    halt_i     = 1'b0;
    kill_i     = 1'b0;
    wb_we_i    = 1'b0;
    wb_addr_i  = '0;
    wb_data_i  = '0;
    ex_ready_i = 1'b1;
    test_name  = "init";
    for (int i = 0; i < `ID_NUM_REGS; i++) begin
      reg_model[i] = '0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;
    test_reset();
    test_alu();
    test_units();
    test_reg0();
    test_illegal();
    test_halt();
    test_kill();
    test_backpressure();
    $display("errors: %0d", error_count);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+hw
hw/isa_pkg.sv
hw/id_pkg.sv
hw/id_pipe_reg.sv
hw/id_decoder.sv
hw/id_regfile.sv
hw/id_operand_sel.sv
hw/id_stage_top.sv
verification/tb_id_stage.sv
